/* config_memory_loader.f */
+incdir+verilog
verilog/stream_pkg.sv
verilog/config_pkg.sv
verilog/config_sequence_decoder.sv
verilog/config_field_assembler.sv
verilog/config_output_fifo.sv
verilog/config_memory_loader.sv
tests/tb_config_memory_loader.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
    --top-module tb_config_memory_loader \
    -f config_memory_loader.f \
    -Mdir obj_dir -o tb_config_memory_loader \
    > build.log 2>&1 \
    && ./obj_dir/tb_config_memory_loader > sim.log 2>&1 \
    && grep -qx "all tests passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }

/* tests/tb_config_memory_loader.sv */
`timescale 1ns/10ps

`include "config_loader_macros.svh"

module tb_config_memory_loader;

    import stream_pkg::*;
    import config_pkg::*;

    localparam int      CLK_PERIOD   = 100;
    localparam int      DRIVE_DELAY  = 10;
    localparam int      RESET_CYCLES = 4;
    localparam offset_t BASE         = 16'd16;
    localparam offset_t WINDOW_END   = BASE + offset_t'(`SEQ_WORDS);
    localparam int      MAX_NOISE    = 3;
    localparam int      NUM_SEQS     = 10;
    localparam int      PUSH_LATENCY = 3;
    // Worst case words driven, plus slack for reset, waits and pops
    localparam int      WATCHDOG_CYCLES = NUM_SEQS * `SEQ_WORDS * (MAX_NOISE + 1) + 200;

    logic       ap_clk;
    logic       areset_fifo;
    logic       response_valid;
    offset_t    response_offset;
    data_word_t response_data;
    logic       config_rd_en;
    logic       config_valid;
    config_t    config_data;
    logic       config_empty;
    logic       config_full;
    logic       fifo_setup;

    logic [31:0] lcg_state;

    // Reference model of the decoder and the record
    logic        model_collect;
    int          model_slot;
    config_t     model_record;
    config_t     expected_q[$];

    config_memory_loader #(
        .SEQ_BASE(BASE)
    ) u_dut (
        .ap_clk          (ap_clk),
        .areset_fifo     (areset_fifo),
        .response_valid  (response_valid),
        .response_offset (response_offset),
        .response_data   (response_data),
        .config_rd_en    (config_rd_en),
        .config_valid    (config_valid),
        .config_data     (config_data),
        .config_empty    (config_empty),
        .config_full     (config_full),
        .fifo_setup      (fifo_setup)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    // ------------------------------------------------------------------------
    // Protocol checks on every edge
    // ------------------------------------------------------------------------
    pop_pulse_check: assert property (@(posedge ap_clk) disable iff (areset_fifo)
        config_valid == $past(config_rd_en && !config_empty))
        else stop_on_error("config_valid does not follow a read of a non-empty FIFO");

    task automatic stop_on_error(input string msg);
        $display("** Error at %0d ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Bits each slot keeps, from the slot layout table
    function automatic data_word_t slot_mask(input int slot);
        if (slot == 0) begin
            return '1;
        end
        case ((slot - 1) % `WORDS_PER_FIELD)
            1:       return `MASK_SHIFT;
            2:       return `MASK_ROUTE_A;
            3:       return `MASK_ROUTE_B;
            4:       return `MASK_CONST;
            6:       return `MASK_OPS;
            default: return '1;
        endcase
    endfunction

    function automatic offset_t outside_offset(input logic [31:0] r);
        offset_t off;
        off = r[15:0];
        if (off >= BASE && off < WINDOW_END) begin
            off = off ^ 16'h8000;
        end
        return off;
    endfunction

    task automatic model_step(input logic valid, input offset_t off, input data_word_t data);
        if (valid && off >= BASE && off < WINDOW_END) begin
            if (!model_collect && off == BASE) begin
                model_collect = 1'b1;
                model_slot    = 0;
                model_record[0 +: `DATA_W] = data & slot_mask(0);
            end else if (model_collect) begin
                model_slot++;
                model_record[model_slot*`DATA_W +: `DATA_W] = data & slot_mask(model_slot);
                if (model_slot == `SEQ_WORDS - 1) begin
                    model_collect = 1'b0;
                    // FIFO drops the record when full
                    if (expected_q.size() < `FIFO_DEPTH) begin
                        expected_q.push_back(model_record);
                    end
                end
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic drive_word(input logic valid, input offset_t off, input data_word_t data);
        @(posedge ap_clk);
        #DRIVE_DELAY;
        response_valid  = valid;
        response_offset = off;
        response_data   = data;
        model_step(valid, off, data);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_word(1'b0, '0, '0);
    endtask

    // Low-valid cycles, out-of-window words, and non-base words while idle
    task automatic send_noise();
        logic [31:0] r;
        int          count;
        r = next_rand();
        count = int'(r[1:0]);
        for (int i = 0; i < count; i++) begin
            r = next_rand();
            case (r[3:2])
                2'd0: drive_word(1'b0, r[31:16], next_rand());
                2'd3: begin
                    if (model_collect) begin
                        drive_word(1'b1, outside_offset(r), next_rand());
                    end else begin
                        drive_word(1'b1, BASE + offset_t'(32'd1 + r % 32'd14), next_rand());
                    end
                end
                default: drive_word(1'b1, outside_offset(r), next_rand());
            endcase
        end
    endtask

    task automatic send_sequence(input bit with_noise);
        offset_t off;
        for (int slot = 0; slot < `SEQ_WORDS; slot++) begin
            if (with_noise) begin
                send_noise();
            end
            if (slot == 0) begin
                off = BASE;
            end else begin
                off = BASE + offset_t'(next_rand() % 32'd15);
            end
            drive_word(1'b1, off, next_rand());
        end
    endtask

    // Last word is sampled on the first idle edge
    task automatic finish_stream();
        int edges;
        drive_word(1'b0, '0, '0);
        edges = 1;
        while (config_empty && edges < 20) begin
            @(posedge ap_clk);
            #DRIVE_DELAY;
            edges++;
        end
        assert (!config_empty)
            else stop_on_error("config_empty never went low after a full sequence");
        assert (edges == PUSH_LATENCY)
            else stop_on_error($sformatf("record reached FIFO after %0d edges, expected %0d",
                                         edges, PUSH_LATENCY));
    endtask

    task automatic pop_and_check();
        config_t expected;
        int      bad_slot;
        expected = expected_q.pop_front();
        @(posedge ap_clk);
        #DRIVE_DELAY;
        config_rd_en = 1'b1;
        @(posedge ap_clk);
        #DRIVE_DELAY;
        config_rd_en = 1'b0;
        assert (config_valid)
            else stop_on_error("config_valid not raised one cycle after read enable");
        bad_slot = -1;
        for (int k = `SEQ_WORDS - 1; k >= 0; k--) begin
            if (config_data[k*`DATA_W +: `DATA_W] !== expected[k*`DATA_W +: `DATA_W]) begin
                bad_slot = k;
            end
        end
        assert (bad_slot < 0)
            else stop_on_error($sformatf("config_data slot %0d is %h, expected %h", bad_slot,
                                         config_data[bad_slot*`DATA_W +: `DATA_W],
                                         expected[bad_slot*`DATA_W +: `DATA_W]));
        @(posedge ap_clk);
        #DRIVE_DELAY;
        assert (!config_valid)
            else stop_on_error("config_valid held longer than one cycle");
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $fatal(1);
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        int edges;
        areset_fifo     = 1'b1;
        response_valid  = 1'b0;
        response_offset = '0;
        response_data   = '0;
        config_rd_en    = 1'b0;
        lcg_state       = 32'h01c547ff;
        model_collect   = 1'b0;
        model_slot      = 0;
        model_record    = '0;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        #DRIVE_DELAY;
        areset_fifo = 1'b0;

        // Reset values and setup window
        assert (!config_valid && !config_full && config_empty && fifo_setup)
            else stop_on_error("outputs do not hold their reset values");
        edges = 0;
        while (fifo_setup && edges <= `SETUP_CYCLES) begin
            @(posedge ap_clk);
            #DRIVE_DELAY;
            edges++;
        end
        assert (edges == `SETUP_CYCLES)
            else stop_on_error($sformatf("fifo_setup fell after %0d edges, expected %0d",
                                         edges, `SETUP_CYCLES));

        // Clean sequence, then sequences with ignored words mixed in
        send_sequence(1'b0);
        finish_stream();
        pop_and_check();
        repeat (2) begin
            send_sequence(1'b1);
            finish_stream();
            pop_and_check();
        end

        // Push order, then a read of the empty FIFO
        send_sequence(1'b1);
        send_sequence(1'b1);
        idle_cycles(PUSH_LATENCY);
        pop_and_check();
        pop_and_check();
        assert (config_empty) else stop_on_error("FIFO not empty after draining");
        @(posedge ap_clk);
        #DRIVE_DELAY;
        config_rd_en = 1'b1;
        @(posedge ap_clk);
        #DRIVE_DELAY;
        config_rd_en = 1'b0;
        assert (!config_valid) else stop_on_error("config_valid raised on an empty FIFO");

        // Overflow, the fifth record is lost
        for (int i = 0; i < `FIFO_DEPTH + 1; i++) begin
            send_sequence(1'b0);
            idle_cycles(PUSH_LATENCY);
            assert (config_full == (i >= `FIFO_DEPTH - 1))
                else stop_on_error($sformatf("config_full is %b after sequence %0d",
                                             config_full, i + 1));
        end
        repeat (`FIFO_DEPTH) pop_and_check();
        assert (config_empty) else stop_on_error("extra record left after overflow");

        $display("all tests passed");
        $finish;
    end

endmodule : tb_config_memory_loader

/* verilog/config_field_assembler.sv */
`timescale 1ns/10ps

`include "config_loader_macros.svh"

module config_field_assembler (
    input  logic                   ap_clk,
    input  logic                   areset_fifo,
    input  logic                   word_valid,
    input  config_pkg::slot_idx_t  word_slot,
    input  stream_pkg::data_word_t word_data,
    output logic                   record_valid,
    output config_pkg::config_t    record_data
);

    import stream_pkg::*;
    import config_pkg::*;

    localparam logic [`SEQ_WORDS-1:0] LANE_ZERO = 1;

    slot_kind_e              word_kind;
    data_word_t              word_mask;
    data_word_t              word_masked;
    logic [`SEQ_WORDS-1:0]   lane_sel;

    // ------------------------------------------------------------------------
    // Slot classification
    // ------------------------------------------------------------------------
    function automatic slot_kind_e classify_slot(slot_idx_t slot);
        int pos;
        if (slot == '0) begin
            return SLOT_HEADER;
        end
        // Position inside the parameter field
        pos = (int'(slot) - 1) % `WORDS_PER_FIELD;
        case (pos)
            0:       return SLOT_INDEX_START;
            1:       return SLOT_SHIFT;
            2:       return SLOT_ROUTE_A;
            3:       return SLOT_ROUTE_B;
            4:       return SLOT_CONST_MASK;
            5:       return SLOT_CONST_VALUE;
            default: return SLOT_OPS_MASK;
        endcase
    endfunction

    function automatic data_word_t kind_mask(slot_kind_e kind);
        case (kind)
            SLOT_SHIFT:      return `MASK_SHIFT;
            SLOT_ROUTE_A:    return `MASK_ROUTE_A;
            SLOT_ROUTE_B:    return `MASK_ROUTE_B;
            SLOT_CONST_MASK: return `MASK_CONST;
            SLOT_OPS_MASK:   return `MASK_OPS;
            // Header, index start and const value keep the whole word
            default:         return '1;
        endcase
    endfunction

    assign word_kind   = classify_slot(word_slot);
    assign word_mask   = kind_mask(word_kind);
    assign word_masked = word_data & word_mask;

    // One-hot lane enable
    assign lane_sel = LANE_ZERO << word_slot;

    // ------------------------------------------------------------------------
    // Record build
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            record_data <= '0;
        end else if (word_valid) begin
            for (int k = 0; k < `SEQ_WORDS; k++) begin
                if (lane_sel[k]) begin
                    record_data[k*`DATA_W +: `DATA_W] <= word_masked;
                end
            end
        end
    end

    // Record is complete in the same cycle the strobe shows
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            record_valid <= 1'b0;
        end else begin
            record_valid <= word_valid && (word_slot == LAST_SLOT);
        end
    end

endmodule : config_field_assembler

/* verilog/config_loader_macros.svh */
`ifndef CONFIG_LOADER_MACROS_SVH
`define CONFIG_LOADER_MACROS_SVH

// ---------------------------------------------------------------------------
// Stream widths
// ---------------------------------------------------------------------------
`define DATA_W             32
`define OFFSET_W           16

// ---------------------------------------------------------------------------
// Sequence layout
// ---------------------------------------------------------------------------
`define NUM_PARAM_FIELDS   2
`define WORDS_PER_FIELD    7
// One header word, then the parameter fields back to back
`define SEQ_WORDS          (1 + `NUM_PARAM_FIELDS * `WORDS_PER_FIELD)

// Output FIFO sizing
`define FIFO_DEPTH         4
`define SETUP_CYCLES       4

// ---------------------------------------------------------------------------
// Per-slot bit masks
// ---------------------------------------------------------------------------
// Shift amount in 4..0, direction in the top bit
`define MASK_SHIFT         32'h8000_001F
`define MASK_ROUTE_A       32'h0000_0FFF
`define MASK_ROUTE_B       32'h0000_FFFF
`define MASK_CONST         32'h0000_000F
`define MASK_OPS           32'h0000_FFFF

`endif

/* verilog/config_memory_loader.sv */
`timescale 1ns/10ps

module config_memory_loader #(
    parameter stream_pkg::offset_t SEQ_BASE = '0
) (
    input  logic                   ap_clk,
    input  logic                   areset_fifo,
    input  logic                   response_valid,
    input  stream_pkg::offset_t    response_offset,
    input  stream_pkg::data_word_t response_data,
    input  logic                   config_rd_en,
    output logic                   config_valid,
    output config_pkg::config_t    config_data,
    output logic                   config_empty,
    output logic                   config_full,
    output logic                   fifo_setup
);

    import stream_pkg::*;
    import config_pkg::*;

    // Decoder to assembler
    logic       word_valid;
    slot_idx_t  word_slot;
    data_word_t word_data;

    // Assembler to FIFO
    logic       record_valid;
    config_t    record_data;

    // ------------------------------------------------------------------------
    // Window filter and slot sequencing
    // ------------------------------------------------------------------------
    config_sequence_decoder #(
        .SEQ_BASE(SEQ_BASE)
    ) u_decoder (
        .ap_clk          (ap_clk),
        .areset_fifo     (areset_fifo),
        .response_valid  (response_valid),
        .response_offset (response_offset),
        .response_data   (response_data),
        .word_valid      (word_valid),
        .word_slot       (word_slot),
        .word_data       (word_data)
    );

    // ------------------------------------------------------------------------
    // Field masking and record build
    // ------------------------------------------------------------------------
    config_field_assembler u_assembler (
        .ap_clk       (ap_clk),
        .areset_fifo  (areset_fifo),
        .word_valid   (word_valid),
        .word_slot    (word_slot),
        .word_data    (word_data),
        .record_valid (record_valid),
        .record_data  (record_data)
    );

    // ------------------------------------------------------------------------
    // Configuration FIFO
    // ------------------------------------------------------------------------
    config_output_fifo u_fifo (
        .ap_clk       (ap_clk),
        .areset_fifo  (areset_fifo),
        .record_valid (record_valid),
        .record_data  (record_data),
        .config_rd_en (config_rd_en),
        .config_valid (config_valid),
        .config_data  (config_data),
        .config_empty (config_empty),
        .config_full  (config_full),
        .fifo_setup   (fifo_setup)
    );

endmodule : config_memory_loader

/* verilog/config_output_fifo.sv */
`timescale 1ns/10ps

`include "config_loader_macros.svh"

module config_output_fifo (
    input  logic                ap_clk,
    input  logic                areset_fifo,
    input  logic                record_valid,
    input  config_pkg::config_t record_data,
    input  logic                config_rd_en,
    output logic                config_valid,
    output config_pkg::config_t config_data,
    output logic                config_empty,
    output logic                config_full,
    output logic                fifo_setup
);

    import config_pkg::*;

    localparam int PTR_W   = $clog2(`FIFO_DEPTH);
    localparam int CNT_W   = $clog2(`FIFO_DEPTH + 1);
    localparam int SETUP_W = $clog2(`SETUP_CYCLES + 1);

    localparam logic [PTR_W-1:0]   LAST_PTR   = PTR_W'(`FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0]   FULL_COUNT = CNT_W'(`FIFO_DEPTH);
    localparam logic [SETUP_W-1:0] SETUP_INIT = SETUP_W'(`SETUP_CYCLES);

    config_t            mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [SETUP_W-1:0] setup_cnt;
    logic               push;
    logic               pop;

    // ------------------------------------------------------------------------
    // Status
    // ------------------------------------------------------------------------
    assign config_empty = (count == '0);
    assign config_full  = (count == FULL_COUNT);
    assign fifo_setup   = (setup_cnt != '0);

    // Pushes during setup or while full are lost
    assign push = record_valid && !config_full && !fifo_setup;
    assign pop  = config_rd_en && !config_empty;

    // Setup window after reset
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            setup_cnt <= SETUP_INIT;
        end else if (setup_cnt != '0) begin
            setup_cnt <= setup_cnt - SETUP_W'(1);
        end
    end

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= record_data;
        end
    end

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            config_valid <= 1'b0;
        end else begin
            config_valid <= pop;
        end
    end

    // Data holds between pops
    always_ff @(posedge ap_clk) begin
        if (pop) begin
            config_data <= mem[rd_ptr];
        end
    end

endmodule : config_output_fifo

/* verilog/config_pkg.sv */
`include "config_loader_macros.svh"

// ---------------------------------------------------------------------------
// Configuration record and slot bookkeeping
// ---------------------------------------------------------------------------
package config_pkg;

    // Slot position inside one sequence, 0 is the header
    typedef logic [3:0] slot_idx_t;

    // Index of the slot that completes a record
    localparam slot_idx_t LAST_SLOT = slot_idx_t'(`SEQ_WORDS - 1);

    // What a slot carries, repeats per parameter field after the header
    typedef enum logic [2:0] {
        SLOT_HEADER,
        SLOT_INDEX_START,
        SLOT_SHIFT,
        SLOT_ROUTE_A,
        SLOT_ROUTE_B,
        SLOT_CONST_MASK,
        SLOT_CONST_VALUE,
        SLOT_OPS_MASK
    } slot_kind_e;

    // Full parallel read/write configuration
    // Slot k sits at bits 32k+31 down to 32k
    typedef logic [`SEQ_WORDS*`DATA_W-1:0] config_t;

    // Decoder state
    typedef enum logic {
        SEQ_IDLE,
        SEQ_COLLECT
    } seq_state_e;

endpackage : config_pkg

/* verilog/config_sequence_decoder.sv */
`timescale 1ns/10ps

`include "config_loader_macros.svh"

module config_sequence_decoder #(
    parameter stream_pkg::offset_t SEQ_BASE = '0
) (
    input  logic                   ap_clk,
    input  logic                   areset_fifo,
    input  logic                   response_valid,
    input  stream_pkg::offset_t    response_offset,
    input  stream_pkg::data_word_t response_data,
    output logic                   word_valid,
    output config_pkg::slot_idx_t  word_slot,
    output stream_pkg::data_word_t word_data
);

    import stream_pkg::*;
    import config_pkg::*;

    // One bit wider so a window near the top of the offset range still works
    localparam logic [`OFFSET_W:0] WINDOW_END =
        {1'b0, SEQ_BASE} + (`OFFSET_W + 1)'(`SEQ_WORDS);

    seq_state_e state;
    slot_idx_t  slot_cnt;
    logic       in_window;
    logic       counted;

    // ------------------------------------------------------------------------
    // Offset window filter
    // ------------------------------------------------------------------------
    assign in_window = (response_offset >= SEQ_BASE) &&
                       ({1'b0, response_offset} < WINDOW_END);
    assign counted   = response_valid && in_window;

    // ------------------------------------------------------------------------
    // Slot sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            state      <= SEQ_IDLE;
            slot_cnt   <= '0;
            word_valid <= 1'b0;
            word_slot  <= '0;
        end else begin
            word_valid <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    // Only the base offset opens a sequence
                    if (counted && (response_offset == SEQ_BASE)) begin
                        word_valid <= 1'b1;
                        word_slot  <= '0;
                        slot_cnt   <= slot_idx_t'(1);
                        state      <= SEQ_COLLECT;
                    end
                end
                SEQ_COLLECT: begin
                    // Any in-window word takes the next slot
                    if (counted) begin
                        word_valid <= 1'b1;
                        word_slot  <= slot_cnt;
                        if (slot_cnt == LAST_SLOT) begin
                            slot_cnt <= '0;
                            state    <= SEQ_IDLE;
                        end else begin
                            slot_cnt <= slot_cnt + slot_idx_t'(1);
                        end
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Payload follows the strobe
    always_ff @(posedge ap_clk) begin
        if (counted) begin
            word_data <= response_data;
        end
    end

endmodule : config_sequence_decoder

/* verilog/stream_pkg.sv */
`include "config_loader_macros.svh"

// ---------------------------------------------------------------------------
// Memory response stream
// ---------------------------------------------------------------------------
package stream_pkg;

    // Word offset within the response burst
    typedef logic [`OFFSET_W-1:0] offset_t;

    // Payload of one response word
    typedef logic [`DATA_W-1:0] data_word_t;

endpackage : stream_pkg
